// File: pipeCtrlPkg.sv
package pipeCtrlPkg;

    localparam int RegIdxBits  = 5;   // 32 gprs
    localparam int ExcCodeBits = 5;   // cp0 cause.excCode width
    localparam int MultLatency = 3;   // busy cycles for mult/multu
    localparam int DivLatency  = 16;  // busy cycles for div/divu

    // down-counter in the mul/div sequencer must hold the longer latency
    localparam int MdCntBits = $clog2(DivLatency + 1);

    typedef logic [RegIdxBits-1:0] regIdxT;

    // source operands of the instruction sitting in ID
    typedef struct packed {
        regIdxT rs;
        regIdxT rt;
        logic   rsUsed;  // rs really read, not just decoded
        logic   rtUsed;
    } srcUseT;

    // load in flight, one per stage (EXE and MEM)
    typedef struct packed {
        logic   isLoad;
        regIdxT dst;     // destination gpr
    } loadDstT;

    // exception request raised by one stage
    typedef struct packed {
        logic                   valid;
        logic [ExcCodeBits-1:0] code;
    } excReqT;

    // which stage won the exception arbitration
    typedef enum logic [2:0] {
        excNone = 3'd0,
        excIf   = 3'd1,
        excId   = 3'd2,
        excExe  = 3'd3,
        excMem  = 3'd4
    } excStageT;

    // per-stage flush from the exception path
    typedef struct packed {
        logic ifs;   // if stage, name clashes with the keyword
        logic id;
        logic exe;
        logic mem;
    } excFlushT;

    // load-use bubble request
    typedef struct packed {
        logic preIfWr;   // 0 = hold pc
        logic idWr;      // 0 = hold if/id
        logic exeFlush;  // 1 = bubble into exe
    } hazardT;

    typedef enum logic [1:0] {
        opNone = 2'd0,
        opMult = 2'd1,
        opDiv  = 2'd2
    } mulDivOpT;

    // everything the controller hands to the datapath
    typedef struct packed {
        logic [2:0] rsvd;  // reserved for growth, always 0
        logic preIfWr;
        logic ifWr;
        logic idWr;
        logic exeWr;
        logic memWr;
        logic mem2Wr;
        logic wbWr;
        logic ifFlush;
        logic idFlush;
        logic exeFlush;
        logic memFlush;
        logic mem2Flush;
        logic wbFlush;
        logic memDisWr;    // kills cp0 write in MEM
        logic wbDisWr;     // kills rf write in WB
        logic icacheFlush;
        logic dcacheFlush;
        logic hiLoKeep;    // 0 = drop pending hi/lo result
    } stageCtrlT;

endpackage

// File: loadUseHazard.sv
`timescale 1ns/1ps

module loadUseHazard
    import pipeCtrlPkg::*;
(
    input  srcUseT  idSrc,    // operands of the ID instruction
    input  loadDstT exeLoad,  // load currently in EXE
    input  loadDstT memLoad,  // load currently in MEM
    output hazardT  hazard
);

    logic exeHit;  // dependence on the EXE load
    logic memHit;  // dependence on the MEM load
    logic stall;

    // true when a load writes a live source of the ID instruction
    function automatic logic srcMatch(input srcUseT src, input loadDstT ld);
        logic rsHit;
        logic rtHit;
        rsHit = src.rsUsed && (src.rs == ld.dst);
        rtHit = src.rtUsed && (src.rt == ld.dst);
        // $zero never carries a dependence
        return ld.isLoad && (ld.dst != '0) && (rsHit || rtHit);
    endfunction

    assign exeHit = srcMatch(idSrc, exeLoad);

    // load data only comes back at the end of MEM2,
    // so a load one stage further down still has to be waited for
    assign memHit = srcMatch(idSrc, memLoad);

    assign stall = exeHit | memHit;

    always_comb begin
        hazard.preIfWr  = ~stall;  // hold pc
        hazard.idWr     = ~stall;  // hold if/id
        hazard.exeFlush = stall;   // bubble goes down the pipe
    end

    // idSrc.rs/rt don't care when the matching used bit is low
    // a single bubble per cycle, the hazard re-evaluates as the load moves on
    // exe case needs two bubbles, mem case one

endmodule

// File: exceptionArbiter.sv
`timescale 1ns/1ps

module exceptionArbiter
    import pipeCtrlPkg::*;
(
    input  logic                   clk,
    input  logic                   rst,
    input  excReqT                 ifExc,
    input  excReqT                 idExc,
    input  excReqT                 exeExc,
    input  excReqT                 memExc,
    output excFlushT               excFlush,  // per-stage flush, same cycle
    output excStageT               entrySel,  // winner, same cycle
    output logic [ExcCodeBits-1:0] excCode,   // registered cause code
    output excStageT               excStage   // registered winner stage
);

    logic [ExcCodeBits-1:0] winCode;  // code of the current winner

    // oldest instruction wins: MEM > EXE > ID > IF
    always_comb begin
        entrySel = excNone;
        winCode  = '0;
        if (memExc.valid) begin
            entrySel = excMem;
            winCode  = memExc.code;
        end
        else if (exeExc.valid) begin
            entrySel = excExe;
            winCode  = exeExc.code;
        end
        else if (idExc.valid) begin
            entrySel = excId;
            winCode  = idExc.code;
        end
        else if (ifExc.valid) begin
            entrySel = excIf;
            winCode  = ifExc.code;
        end
    end

    // winner flushes itself plus every younger stage
    // so each flush is the OR of its own and all older requests
    always_comb begin
        excFlush.mem = memExc.valid;
        excFlush.exe = memExc.valid | exeExc.valid;
        excFlush.id  = memExc.valid | exeExc.valid | idExc.valid;
        excFlush.ifs = memExc.valid | exeExc.valid | idExc.valid | ifExc.valid;
    end

    // cause/stage capture, held until the next exception
    always_ff @(posedge clk) begin
        if (rst) begin
            excStage <= excNone;
            excCode  <= '0;
        end
        else if (entrySel != excNone) begin
            excStage <= entrySel;
            excCode  <= winCode;
        end
    end

    // a younger request in the same cycle is simply dropped here,
    // it re-raises after the refetch if it was real

endmodule

// File: mulDivSequencer.sv
`timescale 1ns/1ps

module mulDivSequencer
    import pipeCtrlPkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  logic     start,     // one-cycle pulse from EXE decode
    input  mulDivOpT op,
    input  logic     hiLoKeep,  // low = exception, abort
    output logic     busy       // holds EXE while high
);

    logic [MdCntBits-1:0] cnt;      // remaining busy cycles
    logic [MdCntBits-1:0] loadVal;  // latency of the requested op
    logic                 launch;   // accepted start

    // latency lookup
    always_comb begin
        case (op)
            opMult:  loadVal = MdCntBits'(MultLatency);
            opDiv:   loadVal = MdCntBits'(DivLatency);
            default: loadVal = '0;  // opNone never goes busy
        endcase
    end

    // starts while busy are ignored, no queueing
    assign launch = start & ~busy;

    // states:
    //   cnt == 0  idle
    //   cnt != 0  running, counts down to idle
    always_ff @(posedge clk) begin
        if (rst) begin
            cnt <= '0;
        end
        else if (!hiLoKeep) begin
            // exception somewhere, kill the op so hi/lo stays untouched
            cnt <= '0;
        end
        else if (busy) begin
            cnt <= cnt - MdCntBits'(1);
        end
        else if (launch) begin
            cnt <= loadVal;  // busy from the next cycle on
        end
    end

    // high for exactly loadVal cycles after the start edge
    assign busy = (cnt != '0);

    // abort beats start in the same cycle,
    // the faulting instruction may well be the mult/div itself
    //
    // the last busy cycle is the one where hi/lo gets written,
    // EXE releases on the following edge

endmodule

// File: wrFlushControl.sv
`timescale 1ns/1ps

module wrFlushControl
    import pipeCtrlPkg::*;
(
    input  hazardT    hazard,         // load-use bubble request
    input  excFlushT  excFlush,       // per-stage exception flush
    input  excStageT  entrySel,       // exception winner
    input  logic      iTlbException,
    input  logic      dTlbException,
    input  logic      icacheBusy,
    input  logic      dcacheBusy,
    input  logic      iTlbStall,
    input  logic      dTlbStall,
    input  logic      branchFailed,   // misprediction resolved in ID
    input  logic      idIsImmJump,    // j/jal in ID
    input  logic      mulDivBusy,
    output stageCtrlT ctrl
);

    logic stall;      // any memory-side back-pressure
    logic exception;  // exception reaching ID or older

    // tlb refill holds the pipe just like a cache miss
    assign stall     = icacheBusy | dcacheBusy | iTlbStall | dTlbStall;
    assign exception = excFlush.id;

    // write enables
    always_comb begin
        // pc register
        if (exception) begin
            ctrl.preIfWr = 1'b1;  // load the handler address
        end
        else if (stall) begin
            ctrl.preIfWr = 1'b0;
        end
        else if (!hazard.preIfWr) begin
            ctrl.preIfWr = 1'b0;  // load-use bubble holds the pc
        end
        else if (branchFailed) begin
            ctrl.preIfWr = 1'b1;  // take the corrected target
        end
        else begin
            ctrl.preIfWr = ~mulDivBusy;
        end

        // if/id
        if (exception) begin
            ctrl.idWr = 1'b1;
        end
        else if (stall || !hazard.idWr) begin
            ctrl.idWr = 1'b0;
        end
        else if (branchFailed) begin
            ctrl.idWr = 1'b1;  // flushed anyway
        end
        else begin
            ctrl.idWr = ~mulDivBusy;
        end

        // id/exe is held only by mul/div or a stall
        if (exception) begin
            ctrl.exeWr = 1'b1;
        end
        else if (stall || mulDivBusy) begin
            ctrl.exeWr = 1'b0;
        end
        else begin
            ctrl.exeWr = 1'b1;
        end

        // back half of the pipe only cares about exception and stall
        ctrl.memWr  = exception | ~stall;
        ctrl.wbWr   = exception | ~stall;  // wb always drains on exception
        ctrl.ifWr   = ctrl.idWr;           // fetch pair moves together
        ctrl.mem2Wr = ctrl.memWr;
    end

    // flushes
    always_comb begin
        ctrl.ifFlush = excFlush.ifs;

        if (excFlush.id) begin
            ctrl.idFlush = 1'b1;
        end
        else if (stall) begin
            ctrl.idFlush = 1'b0;  // keep the slot until the cache is back
        end
        else begin
            ctrl.idFlush = branchFailed;
        end

        if (excFlush.exe) begin
            ctrl.exeFlush = 1'b1;
        end
        else if (stall) begin
            ctrl.exeFlush = 1'b0;  // bubble waits for the stall to end
        end
        else begin
            ctrl.exeFlush = hazard.exeFlush;
        end

        ctrl.memFlush  = excFlush.mem;
        ctrl.mem2Flush = 1'b0;  // older than any flush source
        ctrl.wbFlush   = 1'b0;
    end

    // a MEM exception still commits its cp0/rf effects
    always_comb begin
        ctrl.memDisWr = ~excFlush.mem & stall;
        ctrl.wbDisWr  = ~excFlush.mem & stall;
    end

    // cache flushes
    always_comb begin
        if (exception || iTlbException) begin
            ctrl.icacheFlush = 1'b1;
        end
        else if (stall) begin
            ctrl.icacheFlush = 1'b0;  // icache can't take it while busy
        end
        else begin
            // j/jal redirect fetch from ID and drop the outstanding request
            ctrl.icacheFlush = branchFailed | idIsImmJump;
        end

        ctrl.dcacheFlush = exception | dTlbException;
    end

    always_comb begin
        ctrl.hiLoKeep = (entrySel == excNone);  // any exception aborts mul/div
        ctrl.rsvd     = '0;
    end

endmodule

// File: pipelineControl.sv
`timescale 1ns/1ps

module pipelineControl
    import pipeCtrlPkg::*;
(
    input  logic                   clk,
    input  logic                   rst,
    input  srcUseT                 idSrc,
    input  loadDstT                exeLoad,
    input  loadDstT                memLoad,
    input  excReqT                 ifExc,
    input  excReqT                 idExc,
    input  excReqT                 exeExc,
    input  excReqT                 memExc,
    input  logic                   iTlbException,
    input  logic                   dTlbException,
    input  logic                   icacheBusy,
    input  logic                   dcacheBusy,
    input  logic                   iTlbStall,
    input  logic                   dTlbStall,
    input  logic                   branchFailed,
    input  logic                   idIsImmJump,
    input  logic                   mulDivStart,  // one-cycle pulse
    input  mulDivOpT               mulDivOp,
    output stageCtrlT              ctrl,
    output logic [ExcCodeBits-1:0] excCode,
    output excStageT               excStage,
    output logic                   mulDivBusy
);

    hazardT   hazard;
    excFlushT excFlush;
    excStageT entrySel;

    loadUseHazard u_loadUseHazard (
        .idSrc   (idSrc),
        .exeLoad (exeLoad),
        .memLoad (memLoad),
        .hazard  (hazard)
    );

    exceptionArbiter u_exceptionArbiter (
        .clk      (clk),
        .rst      (rst),
        .ifExc    (ifExc),
        .idExc    (idExc),
        .exeExc   (exeExc),
        .memExc   (memExc),
        .excFlush (excFlush),
        .entrySel (entrySel),
        .excCode  (excCode),
        .excStage (excStage)
    );

    // abort comes back from the priority network
    mulDivSequencer u_mulDivSequencer (
        .clk      (clk),
        .rst      (rst),
        .start    (mulDivStart),
        .op       (mulDivOp),
        .hiLoKeep (ctrl.hiLoKeep),
        .busy     (mulDivBusy)
    );

    wrFlushControl u_wrFlushControl (
        .hazard        (hazard),
        .excFlush      (excFlush),
        .entrySel      (entrySel),
        .iTlbException (iTlbException),
        .dTlbException (dTlbException),
        .icacheBusy    (icacheBusy),
        .dcacheBusy    (dcacheBusy),
        .iTlbStall     (iTlbStall),
        .dTlbStall     (dTlbStall),
        .branchFailed  (branchFailed),
        .idIsImmJump   (idIsImmJump),
        .mulDivBusy    (mulDivBusy),
        .ctrl          (ctrl)
    );

endmodule

// File: tbPipelineControl.sv
`timescale 1ns/1ps

module tbPipelineControl
    import pipeCtrlPkg::*;
();

    localparam int CycleLimit = 600;  // about 76 cycles of reset and tests

    logic                   clk = 1'b0;
    logic                   rst;
    srcUseT                 idSrc;
    loadDstT                exeLoad;
    loadDstT                memLoad;
    excReqT                 ifExc;
    excReqT                 idExc;
    excReqT                 exeExc;
    excReqT                 memExc;
    logic                   iTlbException;
    logic                   dTlbException;
    logic                   icacheBusy;
    logic                   dcacheBusy;
    logic                   iTlbStall;
    logic                   dTlbStall;
    logic                   branchFailed;
    logic                   idIsImmJump;
    logic                   mulDivStart;
    mulDivOpT               mulDivOp;
    stageCtrlT              ctrl;
    logic [ExcCodeBits-1:0] excCode;
    excStageT               excStage;
    logic                   mulDivBusy;

    int     errors = 0;
    int     checks = 0;
    int     cycles = 0;
    integer seed   = 32'h4259_c063;

    always #2 clk = ~clk;  // 4 ns

    pipelineControl u_pipelineControl (
        .clk(clk), .rst(rst), .idSrc(idSrc), .exeLoad(exeLoad), .memLoad(memLoad),
        .ifExc(ifExc), .idExc(idExc), .exeExc(exeExc), .memExc(memExc),
        .iTlbException(iTlbException), .dTlbException(dTlbException),
        .icacheBusy(icacheBusy), .dcacheBusy(dcacheBusy),
        .iTlbStall(iTlbStall), .dTlbStall(dTlbStall),
        .branchFailed(branchFailed), .idIsImmJump(idIsImmJump),
        .mulDivStart(mulDivStart), .mulDivOp(mulDivOp),
        .ctrl(ctrl), .excCode(excCode), .excStage(excStage), .mulDivBusy(mulDivBusy)
    );

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CycleLimit) begin
            $display("timeout: the run did not finish within %0d cycles", CycleLimit);
            $display("TEST FAIL");
            $finish;
        end
    end

    task automatic compareCtrl(input string name, input stageCtrlT exp, input stageCtrlT act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("[ERROR] %s: expected ctrl %b, actual %b", name, exp, act);
        end
    endtask

    task automatic compareStage(input string name, input excStageT exp, input excStageT act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("[ERROR] %s: expected %s, actual %s", name, exp.name(), act.name());
        end
    endtask

    task automatic compareCode(input string name, input logic [ExcCodeBits-1:0] exp,
                               input logic [ExcCodeBits-1:0] act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("[ERROR] %s: expected code %h, actual %h", name, exp, act);
        end
    endtask

    task automatic compareBit(input string name, input logic exp, input logic act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("[ERROR] %s: expected %b, actual %b", name, exp, act);
        end
    endtask

    // quiet pipe with all stages moving and hi/lo kept
    function automatic stageCtrlT idleCtrl();
        stageCtrlT c;
        c = '0;
        {c.preIfWr, c.ifWr, c.idWr, c.exeWr, c.memWr, c.mem2Wr, c.wbWr} = '1;
        c.hiLoKeep = 1'b1;
        return c;
    endfunction

    // memory stall freezes everything and kills rf/cp0 writes
    function automatic stageCtrlT stallCtrl();
        stageCtrlT c;
        c = '0;
        c.memDisWr = 1'b1;
        c.wbDisWr  = 1'b1;
        c.hiLoKeep = 1'b1;
        return c;
    endfunction

    // exception flushes both caches and aborts mul/div
    function automatic stageCtrlT excCtrl();
        stageCtrlT c;
        c = idleCtrl();
        c.icacheFlush = 1'b1;
        c.dcacheFlush = 1'b1;
        c.hiLoKeep    = 1'b0;
        return c;
    endfunction

    function automatic regIdxT randReg();  // 1..31
        return regIdxT'(($random(seed) & 32'h7fff_ffff) % 31 + 1);
    endfunction

    task automatic setIdle();  // call right after a rising edge
        idSrc         <= '0;
        exeLoad       <= '0;
        memLoad       <= '0;
        ifExc         <= '0;
        idExc         <= '0;
        exeExc        <= '0;
        memExc        <= '0;
        iTlbException <= 1'b0;
        dTlbException <= 1'b0;
        icacheBusy    <= 1'b0;
        dcacheBusy    <= 1'b0;
        iTlbStall     <= 1'b0;
        dTlbStall     <= 1'b0;
        branchFailed  <= 1'b0;
        idIsImmJump   <= 1'b0;
        mulDivStart   <= 1'b0;
        mulDivOp      <= opNone;
    endtask

    task automatic resetTest();
        @(negedge clk);
        compareCtrl("reset ctrl", idleCtrl(), ctrl);
        compareBit("reset busy", 1'b0, mulDivBusy);
        compareStage("reset stage", excNone, excStage);
        compareCode("reset code", '0, excCode);
    endtask

    task automatic hazardTest();
        regIdxT    r;
        stageCtrlT bubble;
        bubble = idleCtrl();
        bubble.preIfWr  = 1'b0;
        bubble.idWr     = 1'b0;
        bubble.ifWr     = 1'b0;  // if follows id
        bubble.exeFlush = 1'b1;
        r = randReg();
        @(posedge clk);
        setIdle();
        idSrc   <= '{rs: r, rt: '0, rsUsed: 1'b1, rtUsed: 1'b0};
        exeLoad <= '{isLoad: 1'b1, dst: r};
        @(negedge clk);
        compareCtrl("hazard exe rs", bubble, ctrl);
        r = randReg();
        @(posedge clk);
        setIdle();
        idSrc   <= '{rs: '0, rt: r, rsUsed: 1'b0, rtUsed: 1'b1};
        memLoad <= '{isLoad: 1'b1, dst: r};
        @(negedge clk);
        compareCtrl("hazard mem rt", bubble, ctrl);
        @(posedge clk);
        setIdle();
        idSrc   <= '{rs: '0, rt: '0, rsUsed: 1'b1, rtUsed: 1'b1};
        exeLoad <= '{isLoad: 1'b1, dst: '0};  // $zero
        @(negedge clk);
        compareCtrl("hazard zero reg", idleCtrl(), ctrl);
        @(posedge clk);
        setIdle();
        idSrc   <= '{rs: r, rt: '0, rsUsed: 1'b0, rtUsed: 1'b0};
        exeLoad <= '{isLoad: 1'b1, dst: r};
        @(negedge clk);
        compareCtrl("hazard unused src", idleCtrl(), ctrl);
        @(posedge clk);
        setIdle();
        idSrc      <= '{rs: r, rt: '0, rsUsed: 1'b1, rtUsed: 1'b0};
        exeLoad    <= '{isLoad: 1'b1, dst: r};
        icacheBusy <= 1'b1;  // stall outranks the bubble
        @(negedge clk);
        compareCtrl("hazard under stall", stallCtrl(), ctrl);
    endtask

    task automatic branchTest();
        stageCtrlT exp;
        exp = idleCtrl();
        exp.idFlush     = 1'b1;
        exp.icacheFlush = 1'b1;
        @(posedge clk);
        setIdle();
        branchFailed <= 1'b1;
        @(negedge clk);
        compareCtrl("branch", exp, ctrl);
        compareBit("branch preIfWr", 1'b1, ctrl.preIfWr);
        @(posedge clk);
        dcacheBusy <= 1'b1;  // branch still failing
        @(negedge clk);
        compareCtrl("branch under stall", stallCtrl(), ctrl);
    endtask

    task automatic exceptionTest();
        stageCtrlT exp;
        @(posedge clk);
        setIdle();
        idExc  <= '{valid: 1'b1, code: 5'h0a};
        exeExc <= '{valid: 1'b1, code: 5'h0c};  // older one wins
        @(negedge clk);
        exp = excCtrl();
        {exp.ifFlush, exp.idFlush, exp.exeFlush} = '1;
        compareCtrl("exc id and exe", exp, ctrl);
        compareStage("exc not captured yet", excNone, excStage);
        @(posedge clk);
        setIdle();
        @(negedge clk);
        compareStage("exc stage", excExe, excStage);
        compareCode("exc code", 5'h0c, excCode);
        compareCtrl("exc released", idleCtrl(), ctrl);
        @(posedge clk);
        memExc <= '{valid: 1'b1, code: 5'h04};
        @(negedge clk);
        exp.memFlush = 1'b1;
        compareCtrl("exc mem", exp, ctrl);
        @(posedge clk);
        setIdle();
        dTlbException <= 1'b1;
        @(negedge clk);
        exp = idleCtrl();
        exp.dcacheFlush = 1'b1;
        compareCtrl("dtlb exception", exp, ctrl);
        compareStage("exc mem stage", excMem, excStage);
        compareCode("exc mem code", 5'h04, excCode);
    endtask

    // one busy check per cycle after the start pulse
    // a negative repulseAt means no second pulse
    task automatic mulDivRun(input string name, input mulDivOpT op, input int lat,
                             input int repulseAt);
        @(posedge clk);
        setIdle();
        mulDivStart <= 1'b1;
        mulDivOp    <= op;
        @(negedge clk);
        compareBit({name, " start cycle"}, 1'b0, mulDivBusy);
        for (int i = 0; i <= lat; i++) begin
            @(posedge clk);
            mulDivStart <= (i == repulseAt);
            mulDivOp    <= (i == repulseAt) ? op : opNone;
            @(negedge clk);
            compareBit({name, " busy"}, (i < lat), mulDivBusy);
            if (i < lat) begin
                compareBit({name, " exeWr"}, 1'b0, ctrl.exeWr);
            end
        end
    endtask

    task automatic mulDivAbortTest();
        @(posedge clk);
        setIdle();
        mulDivStart <= 1'b1;
        mulDivOp    <= opDiv;
        @(posedge clk);
        mulDivStart <= 1'b0;
        mulDivOp    <= opNone;
        for (int i = 0; i < 4; i++) begin
            @(negedge clk);
            compareBit("abort busy before", 1'b1, mulDivBusy);
        end
        @(posedge clk);
        exeExc <= '{valid: 1'b1, code: 5'h0d};  // mid-divide fault
        @(negedge clk);
        compareBit("abort busy exc cycle", 1'b1, mulDivBusy);
        compareBit("abort hiLoKeep", 1'b0, ctrl.hiLoKeep);
        @(posedge clk);
        exeExc <= '0;
        @(negedge clk);
        compareBit("abort busy dropped", 1'b0, mulDivBusy);
        @(negedge clk);
        compareBit("abort stays idle", 1'b0, mulDivBusy);
    endtask

    initial begin
        rst <= 1'b1;
        setIdle();
        repeat (16) @(posedge clk);
        rst <= 1'b0;
        resetTest();
        hazardTest();
        branchTest();
        exceptionTest();
        mulDivRun("mult", opMult, MultLatency, -1);
        mulDivRun("div", opDiv, DivLatency, -1);
        mulDivAbortTest();
        mulDivRun("div repulse", opDiv, DivLatency, 4);  // ignored restart
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TEST PASS");
        end
        else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

// File: pipelineControl.f
pipeCtrlPkg.sv
loadUseHazard.sv
exceptionArbiter.sv
mulDivSequencer.sv
wrFlushControl.sv
pipelineControl.sv
tbPipelineControl.sv

// File: Makefile
VERILATOR ?= verilator
TOP       := tbPipelineControl
FILELIST  := pipelineControl.f
VFLAGS    := --binary -j 0 --top-module $(TOP)
OBJDIR    := obj_dir
SIM       := $(OBJDIR)/V$(TOP)
LOG       := sim.log
SRCS      := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --Mdir $(OBJDIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM) | tee $(LOG)
	grep -qx "TEST PASS" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)
